// File: include/mem_access_settings.svh
`ifndef MEM_ACCESS_SETTINGS_SVH
`define MEM_ACCESS_SETTINGS_SVH

// width of the CPU byte address
`define MEM_ADDR_W 32

// log2 of the RAM depth in 32-bit words
// word address bits above this are ignored, so the RAM aliases
`define MEM_RAM_AW 10

`endif

// File: hdl/mem_access_pkg.sv
package mem_access_pkg;

	// access size as presented by the load/store stage
	typedef enum logic [1:0] {
		mem_word = 2'b00,  // 32-bit access, address must be 4-byte aligned
		mem_half = 2'b01,  // 16-bit access, address must be even
		mem_byte = 2'b10   // 8-bit access, any offset
	} mem_size_e;

	// one bus word seen as byte lanes or as halfword lanes
	// lane 0 is the least significant in both views
	typedef union packed {
		logic [3:0][7:0]  bytes;   // bytes[n] at byte offset n
		logic [1:0][15:0] halves;  // halves[n] at byte offset 2*n
	} bus_word_u;

endpackage

// File: hdl/lane_align.sv
`timescale 1ns/100ps
`include "mem_access_settings.svh"

module lane_align (
	input  logic [`MEM_ADDR_W-1:0]      addr_i,    // CPU byte address
	input  mem_access_pkg::mem_size_e   size_i,    // access size
	input  logic                        en_i,      // read or write requested
	input  logic [31:0]                 data_w_i,  // store data, right aligned
	output logic [3:0]                  sel_o,     // byte selects for the bus
	output logic [31:0]                 data_w_o,  // store data in its lane
	output logic                        unalign_o  // illegal offset for the size
);

	import mem_access_pkg::*;

	always_comb begin
		sel_o = 4'b0000;
		data_w_o = 32'h0000_0000;
		unalign_o = 1'b0;
		if (en_i) begin
			case (size_i)
				mem_word: begin
					if (addr_i[1:0] == 2'b00) begin
						sel_o = 4'b1111;
						data_w_o = data_w_i;
					end else begin
						unalign_o = 1'b1;
					end
				end
				mem_half: begin
					if (addr_i[0] == 1'b0) begin
						sel_o = addr_i[1] ? 4'b1100 : 4'b0011;
						data_w_o = {16'h0000, data_w_i[15:0]} << {addr_i[1], 4'b0000};  // 0 or 16
					end else begin
						unalign_o = 1'b1;
					end
				end
				mem_byte: begin
					sel_o = 4'b0001 << addr_i[1:0];
					data_w_o = {24'h00_0000, data_w_i[7:0]} << {addr_i[1:0], 3'b000};
				end
				default: begin
					unalign_o = 1'b1;  // undefined size never reaches the bus
				end
			endcase
		end
	end

endmodule

// File: hdl/wb_master_ctrl.sv
`timescale 1ns/100ps
`include "mem_access_settings.svh"

module wb_master_ctrl (
	input  logic                    wbm_clk_i,
	input  logic                    rst,
	input  logic                    suspend_i,   // abort and hold off accesses
	input  logic                    en_r_i,
	input  logic                    en_w_i,
	input  logic [`MEM_ADDR_W-1:0]  addr_i,
	input  logic [3:0]              sel_i,       // from lane_align
	input  logic [31:0]             data_w_i,    // lane-shifted store data
	input  logic                    unalign_i,
	input  logic [31:0]             wbm_data_i,
	input  logic                    wbm_ack_i,
	output logic                    wbm_cyc_o,
	output logic                    wbm_stb_o,
	output logic                    wbm_we_o,
	output logic [3:0]              wbm_sel_o,
	output logic [`MEM_ADDR_W-3:0]  wbm_addr_o,  // word address
	output logic [31:0]             wbm_data_o,
	output logic [31:0]             rd_word_o,   // raw bus word for load_extract
	output logic                    stall_o
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_bus  = 2'd1;  // wishbone cycle open
	localparam logic [1:0] st_done = 2'd2;  // access finished, result held

	logic [1:0]  state;
	logic [1:0]  next_state;
	logic        req;
	logic        bus_done;
	logic [31:0] rd_word_q;

	assign req = (en_r_i | en_w_i) & ~unalign_i;  // misaligned requests never start
	assign bus_done = wbm_cyc_o & wbm_ack_i;

	always_comb begin
		next_state = st_idle;
		if (!suspend_i) begin
			case (state)
				st_bus:  next_state = bus_done ? st_done : st_bus;
				default: next_state = req ? st_bus : st_idle;  // idle and done both accept
			endcase
		end
	end

	always_ff @(posedge wbm_clk_i) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	// bus outputs follow the next state, as in the reference master
	always_ff @(posedge wbm_clk_i) begin
		if (rst) begin
			wbm_cyc_o <= 1'b0;
			wbm_stb_o <= 1'b0;
			wbm_we_o <= 1'b0;
		end else begin
			wbm_cyc_o <= (next_state == st_bus);
			wbm_stb_o <= (next_state == st_bus);
			wbm_we_o <= (next_state == st_bus) & en_w_i;
		end
	end

	always_ff @(posedge wbm_clk_i) begin
		if (next_state == st_bus) begin  // request is held, reload is harmless
			wbm_sel_o <= sel_i;
			wbm_addr_o <= addr_i[`MEM_ADDR_W-1:2];
			wbm_data_o <= data_w_i;
		end
		if (bus_done) begin
			rd_word_q <= wbm_data_i;
		end
	end

	// forward the word in the ack cycle, which is the first cycle with stall low
	assign rd_word_o = bus_done ? wbm_data_i : rd_word_q;

	assign stall_o = (next_state == st_bus);

endmodule

// File: hdl/load_extract.sv
`timescale 1ns/100ps

module load_extract (
	input  mem_access_pkg::bus_word_u  rd_word_i,   // captured bus word
	input  logic [1:0]                 addr_i,      // byte offset of the load
	input  mem_access_pkg::mem_size_e  size_i,
	input  logic                       sign_ext_i,  // sign or zero fill
	output logic [31:0]                data_r_o
);

	import mem_access_pkg::*;

	logic [15:0] half_lane;
	logic [7:0]  byte_lane;

	assign half_lane = rd_word_i.halves[addr_i[1]];
	assign byte_lane = rd_word_i.bytes[addr_i];

	always_comb begin
		case (size_i)
			mem_half: data_r_o = {{16{sign_ext_i & half_lane[15]}}, half_lane};
			mem_byte: data_r_o = {{24{sign_ext_i & byte_lane[7]}}, byte_lane};
			default:  data_r_o = rd_word_i;  // word load, no extension
		endcase
	end

endmodule

// File: hdl/wb_sram.sv
`timescale 1ns/100ps
`include "mem_access_settings.svh"

module wb_sram (
	input  logic                    wbm_clk_i,
	input  logic                    rst,
	input  logic                    wbs_cyc_i,
	input  logic                    wbs_stb_i,
	input  logic                    wbs_we_i,
	input  logic [3:0]              wbs_sel_i,
	input  logic [`MEM_ADDR_W-3:0]  wbs_addr_i,  // word address
	input  logic [31:0]             wbs_data_i,
	output logic [31:0]             wbs_data_o,
	output logic                    wbs_ack_o
);

	localparam int depth = 1 << `MEM_RAM_AW;

	logic [31:0]            mem [0:depth-1];
	logic [`MEM_RAM_AW-1:0] idx;
	logic                   access;

	assign idx = wbs_addr_i[`MEM_RAM_AW-1:0];  // upper bits dropped, memory aliases
	assign access = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;  // one ack per cycle

	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = 32'h0000_0000;
		end
	end

	always_ff @(posedge wbm_clk_i) begin
		if (access) begin
			wbs_data_o <= mem[idx];
			if (wbs_we_i) begin
				for (int b = 0; b < 4; b++) begin
					if (wbs_sel_i[b]) begin
						mem[idx][8*b +: 8] <= wbs_data_i[8*b +: 8];
					end
				end
			end
		end
	end

	always_ff @(posedge wbm_clk_i) begin
		if (rst) begin
			wbs_ack_o <= 1'b0;
		end else begin
			wbs_ack_o <= access;
		end
	end

endmodule

// File: hdl/mem_access_top.sv
`timescale 1ns/100ps
`include "mem_access_settings.svh"

module mem_access_top (
	input  logic                       wbm_clk_i,
	input  logic                       rst,
	input  logic                       suspend_i,
	input  logic [`MEM_ADDR_W-1:0]     addr_i,
	input  mem_access_pkg::mem_size_e  size_i,
	input  logic                       sign_ext_i,
	input  logic                       en_r_i,
	input  logic                       en_w_i,
	input  logic [31:0]                data_w_i,
	output logic [31:0]                data_r_o,
	output logic                       stall_o,
	output logic                       unalign_o
);

	logic [3:0]              al_sel;      // alignment stage to master
	logic [31:0]             al_data_w;
	logic [31:0]             rd_word;     // master to load stage
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [3:0]              wb_sel;
	logic [`MEM_ADDR_W-3:0]  wb_addr;
	logic [31:0]             wb_data_w;
	logic [31:0]             wb_data_r;
	logic                    wb_ack;

	lane_align u_lane_align (
		.addr_i    (addr_i),
		.size_i    (size_i),
		.en_i      (en_r_i | en_w_i),
		.data_w_i  (data_w_i),
		.sel_o     (al_sel),
		.data_w_o  (al_data_w),
		.unalign_o (unalign_o)
	);

	wb_master_ctrl u_wb_master_ctrl (
		.wbm_clk_i  (wbm_clk_i),
		.rst        (rst),
		.suspend_i  (suspend_i),
		.en_r_i     (en_r_i),
		.en_w_i     (en_w_i),
		.addr_i     (addr_i),
		.sel_i      (al_sel),
		.data_w_i   (al_data_w),
		.unalign_i  (unalign_o),
		.wbm_data_i (wb_data_r),
		.wbm_ack_i  (wb_ack),
		.wbm_cyc_o  (wb_cyc),
		.wbm_stb_o  (wb_stb),
		.wbm_we_o   (wb_we),
		.wbm_sel_o  (wb_sel),
		.wbm_addr_o (wb_addr),
		.wbm_data_o (wb_data_w),
		.rd_word_o  (rd_word),
		.stall_o    (stall_o)
	);

	load_extract u_load_extract (
		.rd_word_i  (rd_word),
		.addr_i     (addr_i[1:0]),
		.size_i     (size_i),
		.sign_ext_i (sign_ext_i),
		.data_r_o   (data_r_o)
	);

	wb_sram u_wb_sram (
		.wbm_clk_i  (wbm_clk_i),
		.rst        (rst),
		.wbs_cyc_i  (wb_cyc),
		.wbs_stb_i  (wb_stb),
		.wbs_we_i   (wb_we),
		.wbs_sel_i  (wb_sel),
		.wbs_addr_i (wb_addr),
		.wbs_data_i (wb_data_w),
		.wbs_data_o (wb_data_r),
		.wbs_ack_o  (wb_ack)
	);

endmodule

// File: testbench/mem_access_assertions.sv
`timescale 1ns/100ps

module mem_access_assertions (
	input logic wbm_clk_i,
	input logic rst,
	input logic cyc_i,      // master cyc
	input logic stb_i,      // master stb
	input logic ack_i,      // slave ack
	input logic unalign_i,  // misaligned request flag
	input logic stall_i
);

	stb_within_cyc: assert property (@(posedge wbm_clk_i) disable iff (rst)
		stb_i |-> cyc_i)
		else $error("wishbone stb high without cyc");

	// a cycle is opened by the request of the previous clock
	no_cycle_on_unalign: assert property (@(posedge wbm_clk_i) disable iff (rst)
		$rose(cyc_i) |-> !$past(unalign_i))
		else $error("wishbone cycle started for a misaligned request");

	ack_within_cyc: assert property (@(posedge wbm_clk_i) disable iff (rst)
		ack_i |-> cyc_i)
		else $error("wishbone ack seen outside a bus cycle");

	bus_idle_after_reset: assert property (@(posedge wbm_clk_i)
		$fell(rst) |-> !stall_i && !cyc_i && !stb_i && !ack_i)
		else $error("stall or bus cycle active in the first cycle after reset");

endmodule

// File: testbench/tb_mem_access.sv
`timescale 1ns/100ps
`include "mem_access_settings.svh"

module tb_mem_access;

	import mem_access_pkg::*;

	localparam int n_word = 24;
	localparam int n_sub = 48;
	localparam int n_mis = 12;
	localparam int n_susp = 6;
	localparam int n_mix = 40;
	localparam int cycle_limit = 4 * 3 * (2*n_word + 2*n_sub + 2*n_mis + 2*n_susp + n_mix);

	logic        wbm_clk_i;
	logic        rst;
	logic        suspend;
	logic [31:0] addr;
	mem_size_e   size;
	logic        sign_ext;
	logic        en_r;
	logic        en_w;
	logic [31:0] data_w;
	logic [31:0] data_r;
	logic        stall;
	logic        unalign;

	integer      seed = 32'h405d_45bc;
	int          errors = 0;
	int          test_errors = 0;
	int          checks = 0;
	int          cycle_count;
	logic [7:0]  model_mem [0:(4 << `MEM_RAM_AW)-1];  // byte image of the SRAM
	logic [31:0] word_addr [0:n_word-1];

	mem_access_top u_dut (
		.wbm_clk_i  (wbm_clk_i),
		.rst        (rst),
		.suspend_i  (suspend),
		.addr_i     (addr),
		.size_i     (size),
		.sign_ext_i (sign_ext),
		.en_r_i     (en_r),
		.en_w_i     (en_w),
		.data_w_i   (data_w),
		.data_r_o   (data_r),
		.stall_o    (stall),
		.unalign_o  (unalign)
	);

	bind wb_master_ctrl mem_access_assertions u_protocol_check (
		.wbm_clk_i (wbm_clk_i),
		.rst       (rst),
		.cyc_i     (wbm_cyc_o),
		.stb_i     (wbm_stb_o),
		.ack_i     (wbm_ack_i),
		.unalign_i (unalign_i),
		.stall_i   (stall_o)
	);

	initial begin
		wbm_clk_i = 1'b0;
		forever #10 wbm_clk_i = ~wbm_clk_i;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge wbm_clk_i);
			cycle_count++;
		end
		$display("run timed out after %0d cycles, an access never completed", cycle_count);
		$display("Done: errors found");
		$finish;
	end

	// little endian, word index wraps at the RAM depth
	function automatic logic [31:0] model_read(input logic [31:0] a, input mem_size_e sz,
			input logic sx);
		int b;
		b = a[`MEM_RAM_AW+1:0];
		case (sz)
			mem_word: return {model_mem[b+3], model_mem[b+2], model_mem[b+1], model_mem[b]};
			mem_half: return {{16{sx & model_mem[b+1][7]}}, model_mem[b+1], model_mem[b]};
			default:  return {{24{sx & model_mem[b][7]}}, model_mem[b]};
		endcase
	endfunction

	task automatic model_write(input logic [31:0] a, input mem_size_e sz, input logic [31:0] wd);
		int b;
		int n;
		b = a[`MEM_RAM_AW+1:0];
		n = (sz == mem_word) ? 4 : (sz == mem_half) ? 2 : 1;
		for (int k = 0; k < n; k++) begin
			model_mem[b+k] = wd[8*k +: 8];  // store data is right aligned
		end
	endtask

	function automatic logic [31:0] near_addr(input mem_size_e sz);
		logic [31:0] a;
		a = $random(seed) & 32'hffff_f03f;  // 16 words, random upper bits alias onto them
		if (sz == mem_word) a[1:0] = 2'b00;
		if (sz == mem_half) a[0] = 1'b0;
		return a;
	endfunction

	function automatic mem_size_e any_size(input bit sub_only);
		int r;
		r = $unsigned($random(seed)) % (sub_only ? 2 : 3);
		return (r == 0) ? mem_byte : (r == 1) ? mem_half : mem_word;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			test_errors++;
			$display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic drive_request(input logic wr, input logic [31:0] a, input mem_size_e sz,
			input logic sx, input logic [31:0] wd, input logic susp);
		@(negedge wbm_clk_i);
		suspend = susp;
		addr = a;
		size = sz;
		sign_ext = sx;
		en_r = ~wr;
		en_w = wr;
		data_w = wd;
		#1;  // let the combinational outputs settle
	endtask

	// request held while stall is high, result taken in the first cycle with stall low
	task automatic run_access(input logic wr, input logic [31:0] a, input mem_size_e sz,
			input logic sx, input logic [31:0] wd);
		int stall_cycles;
		logic [31:0] expected;
		stall_cycles = 0;
		expected = model_read(a, sz, sx);
		drive_request(wr, a, sz, sx, wd, 1'b0);
		while (stall) begin
			stall_cycles++;
			@(negedge wbm_clk_i);
			#1;
		end
		check_value("stall_o cycles", stall_cycles, 2);
		if (wr) begin
			model_write(a, sz, wd);
		end else begin
			check_value("data_r_o", data_r, expected);
			@(posedge wbm_clk_i);
			#1;
			check_value("data_r_o", data_r, expected);  // done cycle, from the captured word
		end
	endtask

	task automatic go_idle(input int n);
		repeat (n) begin
			@(negedge wbm_clk_i);
			suspend = 1'b0;
			en_r = 1'b0;
			en_w = 1'b0;
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, test_errors);
		test_errors = 0;
	endtask

	initial begin
		mem_size_e   sz;
		logic [31:0] a;
		rst = 1'b1;
		suspend = 1'b0;
		addr = 32'h0;
		size = mem_word;
		sign_ext = 1'b0;
		en_r = 1'b0;
		en_w = 1'b0;
		data_w = 32'h0;
		for (int i = 0; i < (4 << `MEM_RAM_AW); i++) begin
			model_mem[i] = 8'h00;  // SRAM starts cleared
		end
		repeat (3) @(posedge wbm_clk_i);
		@(negedge wbm_clk_i);
		rst = 1'b0;

		for (int i = 0; i < n_word; i++) begin
			word_addr[i] = $random(seed) & 32'hffff_fffc;  // anywhere in the address space
			run_access(1'b1, word_addr[i], mem_word, 1'b0, $random(seed));
		end
		for (int i = 0; i < n_word; i++) begin
			run_access(1'b0, word_addr[i], mem_word, 1'b0, 32'h0);
		end
		report_test(1, "aligned word write/read");

		for (int i = 0; i < 2*n_sub; i++) begin
			sz = any_size(1'b1);
			run_access(i < n_sub, near_addr(sz), sz, 1'($random(seed)), $random(seed));
		end
		report_test(2, "half/byte write/read with extension");

		for (int i = 0; i < n_mis; i++) begin
			sz = ($random(seed) & 1) ? mem_word : mem_half;
			a = near_addr(sz) + ((sz == mem_word) ? 32'd1 + $unsigned($random(seed)) % 3 : 32'd1);
			drive_request(1'($random(seed)), a, sz, 1'b0, $random(seed), 1'b0);
			check_value("unalign_o", unalign, 1);
			check_value("stall_o", stall, 0);
			run_access(1'b0, a & 32'hffff_fffc, mem_word, 1'b0, 32'h0);  // word must be untouched
		end
		report_test(3, "misaligned requests");

		for (int i = 0; i < n_susp; i++) begin
			a = near_addr(mem_word);
			drive_request(1'b1, a, mem_word, 1'b0, $random(seed), 1'b1);
			check_value("stall_o", stall, 0);
			@(negedge wbm_clk_i);
			#1;
			check_value("stall_o", stall, 0);
			go_idle(1);
			run_access(1'b0, a, mem_word, 1'b0, 32'h0);
		end
		report_test(4, "suspended write");

		for (int i = 0; i < n_mix; i++) begin
			sz = any_size(1'b0);
			if ($random(seed) & 1) go_idle(1);  // otherwise back to back
			run_access(1'($random(seed)), near_addr(sz), sz, 1'($random(seed)), $random(seed));
		end
		go_idle(2);
		report_test(5, "mixed back-to-back and spaced accesses");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: all.f
+incdir+include
hdl/mem_access_pkg.sv
hdl/lane_align.sv
hdl/wb_master_ctrl.sv
hdl/load_extract.sv
hdl/wb_sram.sv
hdl/mem_access_top.sv
testbench/mem_access_assertions.sv
testbench/tb_mem_access.sv

// File: Bender.yml
package:
  name: mem_access

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/mem_access_pkg.sv
      - hdl/lane_align.sv
      - hdl/wb_master_ctrl.sv
      - hdl/load_extract.sv
      - hdl/wb_sram.sv
      - hdl/mem_access_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/mem_access_assertions.sv
      - testbench/tb_mem_access.sv
